// ==== sim/exec_tests.txt ====
# Columns (hex): name instr pc prediction stall exp_brj_addr exp_mispredict exp_halt
#   exp_wb_wen exp_wb_data (wb_data is only compared when exp_wb_wen is 1)
lui_x1      123450b7 00000200 0 0 00000204 0 0 1 12345000
addi_x2     ffb00113 00000204 0 0 00000208 0 0 1 fffffffb
addi_x3     67808193 00000208 0 0 0000020c 0 0 1 12345678
auipc_x4    00001217 0000020c 0 0 00000210 0 0 1 0000120c
add_x5      002182b3 00000210 0 0 00000214 0 0 1 12345673
sub_x6      40310333 00000214 0 0 00000218 0 0 1 edcba983
slt_x7      003123b3 00000218 0 0 0000021c 0 0 1 00000001
sltu_x8     00313433 0000021c 0 0 00000220 0 0 1 00000000
sra_x9      404354b3 00000220 0 0 00000224 0 0 1 fffedcba
xor_x10     0030c533 00000224 1 0 00000228 1 0 1 00000678
and_x11     0034f5b3 00000228 0 0 0000022c 0 0 1 12345438
beq_taken   00040863 0000022c 1 0 0000023c 0 0 0 00000000
beq_not     00308863 00000230 1 0 00000234 1 0 0 00000000
bne_taken   fe309ce3 00000234 0 0 0000022c 1 0 0 00000000
bne_not     00041863 00000238 0 0 0000023c 0 0 0 00000000
blt_taken   00314863 0000023c 1 0 0000024c 0 0 0 00000000
blt_not     0021c863 00000240 0 0 00000244 0 0 0 00000000
bge_taken   fe21dce3 00000244 0 0 0000023c 1 0 0 00000000
bge_not     00315863 00000248 1 0 0000024c 1 0 0 00000000
bltu_taken  0021e863 0000024c 1 0 0000025c 0 0 0 00000000
bltu_not    00316863 00000250 0 0 00000254 0 0 0 00000000
bgeu_taken  00317863 00000254 0 0 00000264 1 0 0 00000000
bgeu_not    00747863 00000258 1 0 0000025c 1 0 0 00000000
jal_x12     1000066f 0000025c 0 0 0000035c 1 0 1 00000260
jalr_x13    007186e7 00000260 1 0 1234567e 1 0 1 00000264
stall_addi  05500093 00000264 0 1 00000268 0 0 0 00000000
read_x1_old 00008713 00000268 0 0 0000026c 0 0 1 12345000
write_x0    00118013 0000026c 0 0 00000270 0 0 0 00000000
ecall       00000073 00000270 0 0 00000274 0 1 0 00000000
load_lw     0000a783 00000274 0 0 00000278 0 1 0 00000000

// ==== exec_stage.f ====
src/exec_pkg.sv
src/exec_ctrl_if.sv
src/exec_decoder.sv
src/exec_reg_file.sv
src/alu_path.sv
src/branch_resolver.sv
src/writeback_select.sv
src/exec_stage.sv
sim/exec_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

verilator --binary --timing --assert -f exec_stage.f --top-module exec_stage_tb \
  -o exec_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/exec_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim/exec_stage_tb.sv ====
// Testbench for the execute stage: clock, reset, file-driven tests, checks, watchdog, summary
module exec_stage_tb
  import exec_pkg::*;
();

  // ADDI x0,x0,0 held on the bus during reset
  localparam word_t NOP = 32'h0000_0013;

  logic       CLK;
  logic       rst_n;
  word_t      instr;
  word_t      pc;
  logic       prediction;
  logic       stall;
  word_t      brj_addr;
  logic       mispredict;
  logic       halt;
  logic       wb_wen;
  logic [4:0] wb_addr;
  word_t      wb_data;

  // One entry per test line
  string name_q  [$];
  word_t instr_q [$];
  word_t pc_q    [$];
  logic  pred_q  [$];
  logic  stall_q [$];
  word_t brj_q   [$];
  logic  mis_q   [$];
  logic  halt_q  [$];
  logic  wen_q   [$];
  word_t data_q  [$];

  int   test_errors;
  int   pass_count;
  int   fail_count;
  logic tests_loaded = 1'b0;

  exec_stage #(.REG_COUNT(32)) uut (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .instr      (instr),
    .pc         (pc),
    .prediction (prediction),
    .stall      (stall),
    .brj_addr   (brj_addr),
    .mispredict (mispredict),
    .halt       (halt),
    .wb_wen     (wb_wen),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

  // 10-unit clock
  always #5 CLK = ~CLK;

  // Reads the test table, skipping blank and comment lines
  task automatic load_tests(output int ok);
    int    fd;
    int    code;
    string line;
    string name;
    word_t t_instr;
    word_t t_pc;
    word_t t_brj;
    word_t t_data;
    logic  t_pred;
    logic  t_stall;
    logic  t_mis;
    logic  t_halt;
    logic  t_wen;
    ok = 1;
    fd = $fopen("sim/exec_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/exec_tests.txt for reading");
      ok = 0;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, t_instr, t_pc,
                       t_pred, t_stall, t_brj, t_mis, t_halt, t_wen, t_data);
        if (code == 10) begin
          name_q.push_back(name);
          instr_q.push_back(t_instr);
          pc_q.push_back(t_pc);
          pred_q.push_back(t_pred);
          stall_q.push_back(t_stall);
          brj_q.push_back(t_brj);
          mis_q.push_back(t_mis);
          halt_q.push_back(t_halt);
          wen_q.push_back(t_wen);
          data_q.push_back(t_data);
        end else begin
          $display("malformed line in test file: %s", line);
          ok = 0;
        end
      end
    end
    $fclose(fd);
  endtask

  // Compares one output field, counting mismatches for the current test
  task automatic check_field(input string test_name, input string field,
                             input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("ERROR %s %s expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // One test per cycle, driven on the rising edge, checked on the falling edge
  task automatic run_tests();
    for (int i = 0; i < name_q.size(); i++) begin
      @(posedge CLK);
      instr      <= instr_q[i];
      pc         <= pc_q[i];
      prediction <= pred_q[i];
      stall      <= stall_q[i];
      @(negedge CLK);
      test_errors = 0;
      check_field(name_q[i], "brj_addr", brj_q[i], brj_addr);
      check_field(name_q[i], "mispredict", {31'b0, mis_q[i]}, {31'b0, mispredict});
      check_field(name_q[i], "halt", {31'b0, halt_q[i]}, {31'b0, halt});
      check_field(name_q[i], "wb_wen", {31'b0, wen_q[i]}, {31'b0, wb_wen});
      // Write data and index only matter when a write is expected
      if (wen_q[i]) begin
        check_field(name_q[i], "wb_data", data_q[i], wb_data);
        // Destination is the rd field of the RV32I encoding
        check_field(name_q[i], "wb_addr", {27'b0, instr_q[i][11:7]}, {27'b0, wb_addr});
      end
      if (test_errors == 0) begin
        pass_count++;
        $display("PASS %s", name_q[i]);
      end else begin
        fail_count++;
        $display("FAIL %s", name_q[i]);
      end
    end
  endtask

  initial begin
    int ok;
    CLK        = 1'b0;
    rst_n      <= 1'b0;
    instr      <= NOP;
    pc         <= RESET_PC;
    prediction <= 1'b0;
    stall      <= 1'b0;
    pass_count = 0;
    fail_count = 0;
    load_tests(ok);
    if (ok == 0 || name_q.size() == 0) begin
      $display("no usable tests were loaded from the test file");
      $display("tests failed");
    end else begin
      tests_loaded = 1'b1;
      // Reset held for 3 cycles
      repeat (3) @(posedge CLK);
      rst_n <= 1'b1;
      run_tests();
      $display("tests run %0d, passed %0d, failed %0d", name_q.size(), pass_count, fail_count);
      if (fail_count == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
    end
    $finish;
  end

  // Watchdog sized from the number of tests plus reset slack
  initial begin
    wait (tests_loaded === 1'b1);
    #((name_q.size() + 10) * 10);
    $display("timeout: the test sequence did not finish in the expected time");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== src/exec_stage.sv ====
// Execute stage top: decoder, register file, ALU path, branch resolver, write-back select
module exec_stage
  import exec_pkg::*;
#(
  parameter int REG_COUNT = 32
) (
  input  logic       CLK,
  input  logic       rst_n,
  input  word_t      instr,
  input  word_t      pc,
  input  logic       prediction,
  input  logic       stall,
  output word_t      brj_addr,
  output logic       mispredict,
  output logic       halt,
  output logic       wb_wen,
  output logic [4:0] wb_addr,
  output word_t      wb_data
);

  // Decoded control shared by the three consumers
  exec_ctrl_if ctrl ();

  logic [4:0] rs1_addr;
  logic [4:0] rs2_addr;
  logic [4:0] rd_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_result;

  exec_decoder #(.REG_COUNT(REG_COUNT)) decoder (
    .instr    (instr),
    .ctrl     (ctrl),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .halt     (halt)
  );

  // Write port fed back from the write-back trace outputs
  exec_reg_file #(.REG_COUNT(REG_COUNT)) reg_file (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .w_addr   (wb_addr),
    .w_en     (wb_wen),
    .w_data   (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ALU path and resolver run side by side
  alu_path alu (
    .ctrl       (ctrl),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result)
  );

  branch_resolver resolver (
    .ctrl       (ctrl),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .prediction (prediction),
    .brj_addr   (brj_addr),
    .mispredict (mispredict)
  );

  writeback_select wb_sel (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .pc         (pc),
    .rd_addr    (rd_addr),
    .stall      (stall),
    .w_en       (wb_wen),
    .w_addr     (wb_addr),
    .w_data     (wb_data)
  );

endmodule

// ==== src/writeback_select.sv ====
// Write-back source select and stall-gated register write enable
module writeback_select
  import exec_pkg::*;
(
  exec_ctrl_if.writeback ctrl,
  input  word_t          alu_result,
  input  word_t          pc,
  input  logic [4:0]     rd_addr,
  input  logic           stall,
  output logic           w_en,
  output logic [4:0]     w_addr,
  output word_t          w_data
);

  // Link value for JAL and JALR
  word_t pc4;

  assign pc4 = pc + 32'd4;

  always_comb begin
    case (ctrl.w_sel)
      WS_PC4:   w_data = pc4;
      WS_IMM_U: w_data = ctrl.imm;
      default:  w_data = alu_result;
    endcase
  end

  // Stall holds the write; x0 is never written
  assign w_en   = ctrl.wen & ~stall & (rd_addr != '0);
  assign w_addr = rd_addr;

endmodule

// ==== src/branch_resolver.sv ====
// Branch condition, jump and branch targets, redirect address and mispredict
module branch_resolver
  import exec_pkg::*;
(
  exec_ctrl_if.resolver ctrl,
  input  word_t         pc,
  input  word_t         rs1_data,
  input  word_t         rs2_data,
  input  logic          prediction,
  output word_t         brj_addr,
  output logic          mispredict
);

  word_t pc4;
  word_t pc_imm;
  word_t jalr_target;
  logic  taken;

  assign pc4    = pc + 32'd4;
  // Shared by JAL and the conditional branches
  assign pc_imm = pc + ctrl.imm;
  // JALR clears bit 0 of the sum
  assign jalr_target = (rs1_data + ctrl.imm) & ~32'd1;

  // Condition from funct3
  always_comb begin
    case (ctrl.branch_type)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  taken = (rs1_data < rs2_data);
      BR_GEU:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl.jump) begin
      brj_addr   = ctrl.jalr ? jalr_target : pc_imm;
      // Jumps always redirect
      mispredict = 1'b1;
    end else if (ctrl.branch) begin
      brj_addr   = taken ? pc_imm : pc4;
      mispredict = prediction ^ taken;
    end else begin
      // Sequential flow, so any taken prediction was wrong
      brj_addr   = pc4;
      mispredict = prediction;
    end
  end

endmodule

// ==== src/alu_path.sv ====
// Operand selection and the RV32I ALU
module alu_path
  import exec_pkg::*;
(
  exec_ctrl_if.alu ctrl,
  input  word_t    pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output word_t    alu_result
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  // A is rs1 or pc (AUIPC)
  assign op_a = (ctrl.a_sel == AS_PC) ? pc : rs1_data;
  // B is rs2 or the immediate
  assign op_b = (ctrl.b_sel == BS_IMM) ? ctrl.imm : rs2_data;

  // Shift amount from low bits of B only
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = '0;
    endcase
  end

endmodule

// ==== src/exec_reg_file.sv ====
// Register file: two read ports, one write port, register zero reads zero
module exec_reg_file
  import exec_pkg::*;
#(
  parameter int REG_COUNT = 32
) (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic [4:0] rs1_addr,
  input  logic [4:0] rs2_addr,
  input  logic [4:0] w_addr,
  input  logic       w_en,
  input  word_t      w_data,
  output word_t      rs1_data,
  output word_t      rs2_data
);

  word_t regs [REG_COUNT];

  // All registers clear on reset
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && w_addr != '0 && int'(w_addr) < REG_COUNT) begin
      regs[w_addr] <= w_data;
    end
  end

  // Reads are combinational, so a write shows up the next cycle
  assign rs1_data = (rs1_addr == '0 || int'(rs1_addr) >= REG_COUNT) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0 || int'(rs2_addr) >= REG_COUNT) ? '0 : regs[rs2_addr];

endmodule

// ==== src/exec_decoder.sv ====
// Instruction decoder: control levels, immediates, register indexes and halt
module exec_decoder
  import exec_pkg::*;
#(
  parameter int REG_COUNT = 32
) (
  input  word_t         instr,
  exec_ctrl_if.decoder  ctrl,
  output logic [4:0]    rs1_addr,
  output logic [4:0]    rs2_addr,
  output logic [4:0]    rd_addr,
  output logic          halt
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;
  logic       legal_f7;
  logic       illegal;
  logic       use_rs1;
  logic       use_rs2;
  logic       wen_dec;
  logic       bad_reg;

  // funct3 to ALU op; alt picks SUB or SRA
  function automatic aluop_t funct_to_aluop(input logic [2:0] f3, input logic alt);
    aluop_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rd_addr  = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // Format immediates, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // funct7 of 0100000 only exists for SUB and SRA(I)
  assign legal_f7 = (funct7 == 7'b0) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    ctrl.alu_op      = ALU_ADD;
    ctrl.a_sel       = AS_RS1;
    ctrl.b_sel       = BS_RS2;
    ctrl.w_sel       = WS_ALU;
    ctrl.imm         = imm_i;
    ctrl.branch      = 1'b0;
    ctrl.jump        = 1'b0;
    ctrl.jalr        = 1'b0;
    ctrl.branch_type = branch_t'(funct3);
    wen_dec          = 1'b0;
    use_rs1          = 1'b0;
    use_rs2          = 1'b0;
    illegal          = 1'b0;
    case (opcode)
      OP_LUI: begin
        ctrl.w_sel = WS_IMM_U;
        ctrl.imm   = imm_u;
        wen_dec    = 1'b1;
      end
      // pc + U immediate through the ALU
      OP_AUIPC: begin
        ctrl.a_sel = AS_PC;
        ctrl.b_sel = BS_IMM;
        ctrl.imm   = imm_u;
        wen_dec    = 1'b1;
      end
      OP_JAL: begin
        ctrl.w_sel = WS_PC4;
        ctrl.imm   = imm_j;
        ctrl.jump  = 1'b1;
        wen_dec    = 1'b1;
      end
      OP_JALR: begin
        ctrl.w_sel = WS_PC4;
        ctrl.jump  = 1'b1;
        ctrl.jalr  = 1'b1;
        wen_dec    = 1'b1;
        use_rs1    = 1'b1;
        illegal    = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        ctrl.imm    = imm_b;
        ctrl.branch = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        // funct3 010 and 011 are unused
        illegal     = (funct3[2:1] == 2'b01);
      end
      OP_IMM: begin
        ctrl.b_sel  = BS_IMM;
        ctrl.alu_op = funct_to_aluop(funct3, funct3 == 3'b101 && funct7[5]);
        wen_dec     = 1'b1;
        use_rs1     = 1'b1;
        // Shift immediates carry funct7 in the upper bits
        illegal     = (funct3[1:0] == 2'b01) && !legal_f7;
      end
      OP_REG: begin
        ctrl.alu_op = funct_to_aluop(funct3, funct7[5]);
        wen_dec     = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        illegal     = !legal_f7;
      end
      // ECALL and EBREAK stop the core
      OP_SYSTEM: illegal = 1'b1;
      default:   illegal = 1'b1;
    endcase
  end

  // Registers outside the architectural set (RV32E)
  assign bad_reg = (wen_dec && int'(rd_addr) >= REG_COUNT) ||
                   (use_rs1 && int'(rs1_addr) >= REG_COUNT) ||
                   (use_rs2 && int'(rs2_addr) >= REG_COUNT);

  assign halt = illegal | bad_reg;

  // A halting instruction never writes
  assign ctrl.wen = wen_dec & ~halt;

endmodule

// ==== src/exec_ctrl_if.sv ====
// Decoded control and immediate bundle with decoder, ALU, resolver and write-back modports
interface exec_ctrl_if import exec_pkg::*; ();

  aluop_t  alu_op;
  asel_t   a_sel;
  bsel_t   b_sel;
  wsel_t   w_sel;
  // Sign-extended immediate, already chosen by instruction format
  word_t   imm;
  logic    branch;
  logic    jump;
  // Set with jump for JALR, clear for JAL
  logic    jalr;
  branch_t branch_type;
  logic    wen;

  modport decoder (
    output alu_op, a_sel, b_sel, w_sel, imm,
    output branch, jump, jalr, branch_type, wen
  );
  modport alu (input alu_op, a_sel, b_sel, imm);
  modport resolver (input branch, jump, jalr, branch_type, imm);
  modport writeback (input w_sel, imm, wen);

endinterface

// ==== src/exec_pkg.sv ====
// Shared types for the execute stage: word, opcode, ALU, branch and select enums, reset pc
package exec_pkg;

  // One data or address word
  typedef logic [31:0] word_t;

  // Where fetch starts after reset
  localparam word_t RESET_PC = 32'h0000_0200;

  // RV32I major opcodes handled by this stage
  // Loads, stores and everything else decode as illegal
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } aluop_t;

  // Branch conditions, encoded as funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_t;

  // Write-back source
  typedef enum logic [1:0] {WS_ALU, WS_PC4, WS_IMM_U} wsel_t;

  // ALU operand sources
  typedef enum logic {AS_RS1, AS_PC} asel_t;
  typedef enum logic {BS_RS2, BS_IMM} bsel_t;

endpackage
